// File: vga_display_top.f
design/vga_pkg.sv
design/vga_timing.sv
design/tile_pattern.sv
design/palette_ram.sv
design/vga_display_top.sv
verification/vga_display_checker.sv
verification/vga_display_tb.sv

// File: Makefile
# Verilator build and run for the VGA display testbench.

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := vga_display_tb
FILELIST := vga_display_top.f
OBJ_DIR  := obj_dir
PASS_MSG := TB PASSED

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/vga_display_tb.sv
// vga display testbench: runs a tiny screen through reset, sync timing, window, color and write tests.
`default_nettype none

module vga_display_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_sync   = 4;
    localparam int h_back   = 3;
    localparam int h_active = 32;
    localparam int h_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_back   = 2;
    localparam int v_active = 16;
    localparam int v_front  = 1;

    localparam int h_total      = h_sync + h_back + h_active + h_front;
    localparam int v_total      = v_sync + v_back + v_active + v_front;
    localparam int frame_cycles = h_total * v_total;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 3;

    // six frames of tests, the reset and some slack.
    localparam int watchdog_cycles = 6 * frame_cycles + reset_cycles + 200;

    logic                vga_clk;
    logic                rst_n;
    logic                wr_valid;
    vga_pkg::pal_index_t wr_index;
    vga_pkg::color_t     wr_color;
    logic                wr_ready;
    logic                hsync;
    logic                vsync;
    logic                de;
    vga_pkg::color_t     rgb;

    vga_pkg::color_t     exp_pal [vga_pkg::pal_depth]; // colors the host has written.
    logic [31:0]         lfsr_state;
    int                  pass_count;
    int                  fail_count;

    vga_display_top #(
        .h_sync   (h_sync),
        .h_back   (h_back),
        .h_active (h_active),
        .h_front  (h_front),
        .v_sync   (v_sync),
        .v_back   (v_back),
        .v_active (v_active),
        .v_front  (v_front)
    ) u_vga_display_top (
        .vga_clk  (vga_clk),
        .rst_n    (rst_n),
        .wr_valid (wr_valid),
        .wr_index (wr_index),
        .wr_color (wr_color),
        .wr_ready (wr_ready),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .rgb      (rgb)
    );

    always #(clk_period / 2) vga_clk = ~vga_clk;

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.
        end
        return n;
    endfunction

    task automatic next_color(output vga_pkg::color_t c);
        c = '0;
        for (int b = 0; b < 12; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            c = {c[10:0], lfsr_state[0]};
        end
    endtask

    task automatic check_color(input string name, input vga_pkg::color_t got,
                               input vga_pkg::color_t exp);
        if (got !== exp) begin
            fail_count++;
            $display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_coord(input string name, input vga_pkg::coord_t got,
                               input vga_pkg::coord_t exp);
        if (got !== exp) begin
            fail_count++;
            $display("Fail at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_count++;
            $display("Fail at %0t: %s got %b, expected %b", $time, name, got, exp);
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_failure(input string what);
        fail_count++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failures", name, fail_count - fails_before);
        end
    endtask

    task automatic wait_vsync_fall(output int cycles);
        logic prev;
        prev   = vsync;
        cycles = 0;
        forever begin
            @(negedge vga_clk);
            cycles++;
            if (prev && !vsync) break;
            if (cycles > 2 * frame_cycles) begin
                report_failure("vsync never fell");
                break;
            end
            prev = vsync;
        end
    endtask

    // host side of the handshake, inputs change on the falling edge.
    task automatic write_entry(input vga_pkg::pal_index_t index, input vga_pkg::color_t color,
                               output int stall);
        wr_valid = 1'b1;
        wr_index = index;
        wr_color = color;
        stall    = 0;
        while (!wr_ready && stall <= h_active + 2) begin
            @(negedge vga_clk);
            stall++;
        end
        if (!wr_ready) begin
            report_failure("palette write was never accepted");
        end else begin
            exp_pal[index] = color;
            @(negedge vga_clk); // accepted on the rising edge in between.
        end
        wr_valid = 1'b0;
    endtask

    // one frame of samples, row restarts while vsync is low.
    task automatic check_frame_colors(output int pixels);
        int   col;
        int   row;
        int   idx;
        logic in_run;
        col    = 0;
        row    = 0;
        in_run = 1'b0;
        pixels = 0;
        for (int i = 0; i < frame_cycles; i++) begin
            if (!vsync) row = 0;
            if (de) begin
                idx = ((col >> vga_pkg::tile_log2) + (row >> vga_pkg::tile_log2))
                      % vga_pkg::pal_depth;
                check_color("rgb", rgb, exp_pal[idx]);
                col++;
                pixels++;
                in_run = 1'b1;
            end else begin
                check_color("rgb", rgb, 12'h000);
                if (in_run) row++;
                col    = 0;
                in_run = 1'b0;
            end
            @(negedge vga_clk);
        end
    endtask

    task automatic check_reset_outputs();
        check_bit("de", de, 1'b0);
        check_bit("hsync", hsync, 1'b1);
        check_bit("vsync", vsync, 1'b1);
        check_color("rgb", rgb, 12'h000);
        check_bit("wr_ready", wr_ready, 1'b1);
    endtask

    task automatic test_reset_state();
        int fails_before;
        fails_before = fail_count;
        repeat (reset_cycles) begin
            @(negedge vga_clk);
            check_reset_outputs();
        end
        rst_n = 1'b1;
        @(negedge vga_clk);
        check_reset_outputs(); // first cycle out of reset still shows the reset state.
        report_test("reset_state", fails_before);
    endtask

    task automatic test_sync_timing();
        int   fails_before;
        int   cycles;
        int   h_period;
        int   h_low;
        int   v_low;
        logic prev_h;
        logic prev_v;
        fails_before = fail_count;
        wait_vsync_fall(cycles);
        prev_h   = 1'b0;
        prev_v   = 1'b0;
        h_period = 0;
        h_low    = 1;
        v_low    = 1;
        cycles   = 0;
        forever begin
            @(negedge vga_clk);
            cycles++;
            h_period++;
            if (prev_h && !hsync) begin
                check_coord("hsync period", vga_pkg::coord_t'(h_period),
                            vga_pkg::coord_t'(h_total));
                h_period = 0;
            end
            if (!prev_h && hsync) begin
                check_coord("hsync low cycles", vga_pkg::coord_t'(h_low),
                            vga_pkg::coord_t'(h_sync));
            end
            if (!hsync) h_low = prev_h ? 1 : h_low + 1;
            if (!prev_v && vsync) begin
                check_coord("vsync low cycles", vga_pkg::coord_t'(v_low),
                            vga_pkg::coord_t'(v_sync * h_total));
            end
            if (!vsync) v_low = prev_v ? 1 : v_low + 1;
            if (prev_v && !vsync) begin
                check_coord("vsync period", vga_pkg::coord_t'(cycles),
                            vga_pkg::coord_t'(frame_cycles));
                break;
            end
            if (cycles > 2 * frame_cycles) begin
                report_failure("second vsync pulse never came");
                break;
            end
            prev_h = hsync;
            prev_v = vsync;
        end
        report_test("sync_timing", fails_before);
    endtask

    // starts on the sample where vsync falls.
    task automatic test_visible_window();
        int   fails_before;
        int   de_count;
        int   de_first;
        int   de_runs;
        int   de_lines;
        int   first_line;
        logic prev_de;
        fails_before = fail_count;
        de_lines     = 0;
        first_line   = -1;
        for (int line = 0; line < v_total; line++) begin
            de_count = 0;
            de_first = -1;
            de_runs  = 0;
            prev_de  = 1'b0;
            check_bit("hsync at line start", hsync, 1'b0);
            for (int i = 0; i < h_total; i++) begin
                if (de && !prev_de) de_runs++;
                if (de && de_first < 0) de_first = i;
                if (de) de_count++;
                prev_de = de;
                @(negedge vga_clk);
            end
            if (de_count != 0) begin
                if (de_lines == 0) first_line = line;
                de_lines++;
                check_coord("de cycles in line", vga_pkg::coord_t'(de_count),
                            vga_pkg::coord_t'(h_active));
                check_coord("de start after hsync fall", vga_pkg::coord_t'(de_first),
                            vga_pkg::coord_t'(h_sync + h_back));
                if (de_runs != 1) report_failure("de was not one unbroken run in a line");
            end
        end
        check_coord("lines with de", vga_pkg::coord_t'(de_lines), vga_pkg::coord_t'(v_active));
        check_coord("first de line after vsync fall", vga_pkg::coord_t'(first_line),
                    vga_pkg::coord_t'(v_sync + v_back));
        report_test("visible_window", fails_before);
    endtask

    task automatic test_pattern_colors();
        int              fails_before;
        int              stall;
        int              pixels;
        vga_pkg::color_t c;
        fails_before = fail_count;
        for (int i = 0; i < vga_pkg::pal_depth; i++) begin
            next_color(c);
            write_entry(vga_pkg::pal_index_t'(i), c, stall);
        end
        check_frame_colors(pixels);
        check_coord("visible pixels", vga_pkg::coord_t'(pixels),
                    vga_pkg::coord_t'(h_active * v_active));
        report_test("pattern_colors", fails_before);
    endtask

    task automatic test_write_backpressure();
        int              fails_before;
        int              stall;
        int              cycles;
        int              pixels;
        vga_pkg::color_t c;
        fails_before = fail_count;
        cycles       = 0;
        while (!de && cycles <= frame_cycles) begin
            @(negedge vga_clk);
            cycles++;
        end
        if (!de) report_failure("de never went high");
        next_color(c);
        if (c == exp_pal[3]) c = ~c;
        // index 3 lands on tiles that the small screen shows.
        write_entry(4'd3, c, stall);
        // the palette read leads the output by one cycle.
        check_coord("cycles stalled", vga_pkg::coord_t'(stall), vga_pkg::coord_t'(h_active - 1));
        check_bit("de after write", de, 1'b0);
        wait_vsync_fall(cycles);
        check_frame_colors(pixels);
        check_coord("visible pixels", vga_pkg::coord_t'(pixels),
                    vga_pkg::coord_t'(h_active * v_active));
        report_test("write_backpressure", fails_before);
    endtask

    initial begin
        vga_clk    = 1'b0;
        rst_n      = 1'b0;
        wr_valid   = 1'b0;
        wr_index   = '0;
        wr_color   = '0;
        lfsr_state = 32'h513f;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < vga_pkg::pal_depth; i++) begin
            exp_pal[i] = '0; // palette clears on reset.
        end
        test_reset_state();
        test_sync_timing();
        test_visible_window();
        test_pattern_colors();
        test_write_backpressure();
        if (u_vga_display_top.u_checker.assert_errors != 0) begin
            report_failure("protocol assertions failed");
        end
        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/vga_display_checker.sv
// vga display checker: protocol assertions on the output pixels, syncs and write port.
`default_nettype none

module vga_display_checker (
    input wire logic            vga_clk,
    input wire logic            rst_n,
    input wire logic            hsync,
    input wire logic            vsync,
    input wire logic            de,
    input wire vga_pkg::color_t rgb,
    input wire logic            wr_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    rgb_black_in_blank: assert property (@(posedge vga_clk) disable iff (!rst_n)
        !de |-> rgb == 12'h000)
        else begin
            $error("rgb is not black while de is low");
            assert_errors++;
        end

    de_outside_sync: assert property (@(posedge vga_clk) disable iff (!rst_n)
        de |-> hsync && vsync)
        else begin
            $error("de is high during a sync pulse");
            assert_errors++;
        end

    // a pixel on screen was looked up one cycle earlier, with the host stalled.
    ready_low_on_read: assert property (@(posedge vga_clk) disable iff (!rst_n)
        wr_ready |=> !de)
        else begin
            $error("wr_ready was high while a visible pixel was looked up");
            assert_errors++;
        end

    sync_high_at_release: assert property (@(posedge vga_clk)
        $rose(rst_n) |-> hsync && vsync)
        else begin
            $error("sync low on the first edge after reset");
            assert_errors++;
        end

    sync_high_after_release: assert property (@(posedge vga_clk)
        $rose(rst_n) |=> hsync && vsync)
        else begin
            $error("sync low before the first counter position");
            assert_errors++;
        end

endmodule

bind vga_display_top vga_display_checker u_checker (
    .vga_clk  (vga_clk),
    .rst_n    (rst_n),
    .hsync    (hsync),
    .vsync    (vsync),
    .de       (de),
    .rgb      (rgb),
    .wr_ready (wr_ready)
);

`default_nettype wire

// File: design/vga_display_top.sv
// vga display top: timing, tile pattern and palette joined into one pixel pipeline.
`default_nettype none

module vga_display_top #(
    parameter int h_sync   = 64,
    parameter int h_back   = 120,
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int v_sync   = 3,
    parameter int v_back   = 16,
    parameter int v_active = 480,
    parameter int v_front  = 1
) (
    input  wire logic                 vga_clk,
    input  wire logic                 rst_n,
    input  wire logic                 wr_valid,
    input  wire vga_pkg::pal_index_t  wr_index,
    input  wire vga_pkg::color_t      wr_color,
    output logic                      wr_ready,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      de,
    output vga_pkg::color_t           rgb
);

    logic                t_hsync;
    logic                t_vsync;
    logic                t_de;
    vga_pkg::coord_t     t_column;
    vga_pkg::coord_t     t_row;
    logic                rd_en;
    vga_pkg::pal_index_t rd_index;

    vga_timing #(
        .h_sync   (h_sync),
        .h_back   (h_back),
        .h_active (h_active),
        .h_front  (h_front),
        .v_sync   (v_sync),
        .v_back   (v_back),
        .v_active (v_active),
        .v_front  (v_front)
    ) u_timing (
        .vga_clk (vga_clk),
        .rst_n   (rst_n),
        .hsync   (t_hsync),
        .vsync   (t_vsync),
        .de      (t_de),
        .column  (t_column),
        .row     (t_row)
    );

    // index is formed in the same cycle the palette samples it.
    tile_pattern u_pattern (
        .vga_clk  (vga_clk),
        .rst_n    (rst_n),
        .in_hsync (t_hsync),
        .in_vsync (t_vsync),
        .in_de    (t_de),
        .column   (t_column),
        .row      (t_row),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de)
    );

    palette_ram u_palette (
        .vga_clk  (vga_clk),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rgb      (rgb),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_index (wr_index),
        .wr_color (wr_color)
    );

endmodule

`default_nettype wire

// File: design/palette_ram.sv
// palette ram: 16-color lookup with registered read and a write port open only in blanking.
`default_nettype none

module palette_ram (
    input  wire logic                 vga_clk,
    input  wire logic                 rst_n,
    input  wire logic                 rd_en,
    input  wire vga_pkg::pal_index_t  rd_index,
    output vga_pkg::color_t           rgb,
    input  wire logic                 wr_valid,
    output logic                      wr_ready,
    input  wire vga_pkg::pal_index_t  wr_index,
    input  wire vga_pkg::color_t      wr_color
);

    vga_pkg::color_t mem [vga_pkg::pal_depth];
    logic            wr_fire;

    // host is stalled while visible pixels are being looked up.
    assign wr_ready = !rd_en;
    assign wr_fire  = wr_valid && wr_ready;

    // color table, cleared to black on reset.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < vga_pkg::pal_depth; i++) begin
                mem[i] <= vga_pkg::color_black;
            end
        end else if (wr_fire) begin
            mem[wr_index] <= wr_color;
        end
    end

    // read port, black outside the window.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= vga_pkg::color_black;
        end else if (rd_en) begin
            rgb <= mem[rd_index];
        end else begin
            rgb <= vga_pkg::color_black;
        end
    end

endmodule

`default_nettype wire

// File: design/tile_pattern.sv
// tile pattern: maps pixel address to a diagonal-band palette index and aligns the syncs.
`default_nettype none

module tile_pattern (
    input  wire logic              vga_clk,
    input  wire logic              rst_n,
    input  wire logic              in_hsync,
    input  wire logic              in_vsync,
    input  wire logic              in_de,
    input  wire vga_pkg::coord_t   column,
    input  wire vga_pkg::coord_t   row,
    output logic                   rd_en,
    output vga_pkg::pal_index_t    rd_index,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   de
);

    vga_pkg::coord_t tile_col;
    vga_pkg::coord_t tile_row;
    vga_pkg::coord_t tile_sum;

    assign tile_col = column >> vga_pkg::tile_log2;
    assign tile_row = row >> vga_pkg::tile_log2;
    assign tile_sum = tile_col + tile_row;

    // low bits of the tile sum wrap through the palette.
    assign rd_index = vga_pkg::pal_index_t'(tile_sum);
    assign rd_en    = in_de;

    // one stage to line up with the registered palette read.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= in_hsync;
            vsync <= in_vsync;
            de    <= in_de;
        end
    end

endmodule

`default_nettype wire

// File: design/vga_timing.sv
// vga timing: horizontal and vertical counters with registered syncs, display-enable and address.
`default_nettype none

module vga_timing #(
    parameter int h_sync   = 64,
    parameter int h_back   = 120,
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int v_sync   = 3,
    parameter int v_back   = 16,
    parameter int v_active = 480,
    parameter int v_front  = 1
) (
    input  wire logic           vga_clk,
    input  wire logic           rst_n,
    output logic                hsync,
    output logic                vsync,
    output logic                de,
    output vga_pkg::coord_t     column,
    output vga_pkg::coord_t     row
);

    localparam int h_total = h_sync + h_back + h_active + h_front;
    localparam int v_total = v_sync + v_back + v_active + v_front;

    // window edges in counter terms.
    localparam vga_pkg::coord_t h_sync_end  = vga_pkg::coord_t'(h_sync);
    localparam vga_pkg::coord_t h_vis_start = vga_pkg::coord_t'(h_sync + h_back);
    localparam vga_pkg::coord_t h_vis_end   = vga_pkg::coord_t'(h_sync + h_back + h_active);
    localparam vga_pkg::coord_t h_last      = vga_pkg::coord_t'(h_total - 1);

    localparam vga_pkg::coord_t v_sync_end  = vga_pkg::coord_t'(v_sync);
    localparam vga_pkg::coord_t v_vis_start = vga_pkg::coord_t'(v_sync + v_back);
    localparam vga_pkg::coord_t v_vis_end   = vga_pkg::coord_t'(v_sync + v_back + v_active);
    localparam vga_pkg::coord_t v_last      = vga_pkg::coord_t'(v_total - 1);

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;
    logic            h_wrap;
    logic            h_vis;
    logic            v_vis;
    logic            visible;

    assign h_wrap  = (h_cnt == h_last);
    assign h_vis   = (h_cnt >= h_vis_start) && (h_cnt < h_vis_end);
    assign v_vis   = (v_cnt >= v_vis_start) && (v_cnt < v_vis_end);
    assign visible = h_vis && v_vis;

    // pixel counter, zero based.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // line counter steps once per line.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_cnt == v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // syncs and window flag, one cycle behind the counters.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= (h_cnt >= h_sync_end); // low during the pulse.
            vsync <= (v_cnt >= v_sync_end);
            de    <= visible;
        end
    end

    // address is held at zero outside the window.
    always_ff @(posedge vga_clk or negedge rst_n) begin
        if (!rst_n) begin
            column <= '0;
            row    <= '0;
        end else if (visible) begin
            column <= h_cnt - h_vis_start;
            row    <= v_cnt - v_vis_start;
        end else begin
            column <= '0;
            row    <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/vga_pkg.sv
// vga display package: shared pixel, coordinate and palette types and tile constants.
`default_nettype none

package vga_pkg;

    // counter, column and row positions.
    typedef logic [10:0] coord_t;

    // one pixel as 4-bit red, green and blue.
    typedef logic [11:0] color_t;

    // palette address.
    typedef logic [3:0] pal_index_t;

    // tile edge is 2**tile_log2 pixels.
    localparam int tile_log2 = 3;

    // number of palette entries, must cover every pal_index_t value.
    localparam int pal_depth = 16;

    // black output outside the visible window.
    localparam color_t color_black = 12'h000;

endpackage

`default_nettype wire
